//--- include/txSelLogic_params.svh
// Transmit select logic constants

`ifndef TX_SEL_LOGIC_PARAMS_SVH
`define TX_SEL_LOGIC_PARAMS_SVH

// Number of transmit primary controllers
// One beacon channel plus four access categories
`define TX_NUM_CHAN 5

// Width of a status pointer from a primary controller
`define TX_PTR_WIDTH 32

// Bit positions inside a channel vector
// Beacon sits on the most significant bit
`define TX_CHAN_BCN 4
`define TX_CHAN_AC0 3
`define TX_CHAN_AC1 2
`define TX_CHAN_AC2 1
`define TX_CHAN_AC3 0

`endif

//--- src/txSelLogicPkg.sv
// Transmit select logic types

`include "txSelLogic_params.svh"

package txSelLogicPkg;

  // --------------------------------------------------------------------------
  // Channel vectors
  // --------------------------------------------------------------------------

  // One bit per primary controller, beacon on the MSB
  // Used for triggers, the captured select, routed strobes and error flags
  typedef logic [`TX_NUM_CHAN-1:0] chanVec_t;

  // --------------------------------------------------------------------------
  // Status pointers
  // --------------------------------------------------------------------------

  // Single status pointer as seen by the list processor
  typedef logic [`TX_PTR_WIDTH-1:0] statusPtr_t;

  // Status pointers of all channels
  // Entry index matches the bit index of chanVec_t
  typedef statusPtr_t [`TX_NUM_CHAN-1:0] statusPtrArr_t;

endpackage

//--- src/txChanRouter.sv
// Transmit channel router

`timescale 1ns/1ps

`include "txSelLogic_params.svh"

module txChanRouter
  import txSelLogicPkg::*;
(
  // Clock and resets
  input  logic          macPITxClk,
  input  logic          macPITxClkHardRst_n,
  input  logic          macPITxClkSoftRst_n,
  // Primary controller side
  input  chanVec_t      chanTrig,
  input  statusPtrArr_t chanStatusPtr,
  // List processor strobes
  input  logic          trigHalt,
  input  logic          trigDead,
  input  logic          nxtAtomFrmPtrValid,
  input  logic          nxtMpduDescValid,
  // Towards the list processor
  output logic          trigTxListProc,
  output statusPtr_t    statusPointer,
  // Routed strobes towards the primary controllers
  output chanVec_t      chanHalt,
  output chanVec_t      chanDead,
  output chanVec_t      chanNxtAtomFrmPtrValid,
  output chanVec_t      chanNxtMpduDescValid
);

  // Captured active channel
  chanVec_t selectVec;
  // Combined trigger one cycle late
  logic     trigTxListProcDly;

  // --------------------------------------------------------------------------
  // Combined trigger and select capture
  // --------------------------------------------------------------------------

  // Only one controller is active at a time
  // Its trigger is a level held through the whole transfer
  assign trigTxListProc = |chanTrig;

  // Delayed trigger for rising edge detection
  always_ff @(posedge macPITxClk or negedge macPITxClkHardRst_n)
  begin
    if (!macPITxClkHardRst_n)
      trigTxListProcDly <= 1'b0;
    else if (!macPITxClkSoftRst_n)
      trigTxListProcDly <= 1'b0;
    else
      trigTxListProcDly <= trigTxListProc;
  end

  // Load the trigger pattern on the rising edge of the combined trigger
  // Select holds after the trigger drops, so the pointer stays visible
  always_ff @(posedge macPITxClk or negedge macPITxClkHardRst_n)
  begin
    if (!macPITxClkHardRst_n)
      selectVec <= '0;
    else if (!macPITxClkSoftRst_n)
      selectVec <= '0;
    else if (trigTxListProc && !trigTxListProcDly)
      selectVec <= chanTrig;
  end

  // --------------------------------------------------------------------------
  // Status pointer mux
  // --------------------------------------------------------------------------

  // One-hot select picks a pointer
  // Empty or multi-bit select gives zero
  always_comb
  begin
    case (selectVec)
      chanVec_t'(1 << `TX_CHAN_BCN): statusPointer = chanStatusPtr[`TX_CHAN_BCN];
      chanVec_t'(1 << `TX_CHAN_AC0): statusPointer = chanStatusPtr[`TX_CHAN_AC0];
      chanVec_t'(1 << `TX_CHAN_AC1): statusPointer = chanStatusPtr[`TX_CHAN_AC1];
      chanVec_t'(1 << `TX_CHAN_AC2): statusPointer = chanStatusPtr[`TX_CHAN_AC2];
      chanVec_t'(1 << `TX_CHAN_AC3): statusPointer = chanStatusPtr[`TX_CHAN_AC3];
      default:                       statusPointer = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Strobe routing
  // --------------------------------------------------------------------------

  // Halt and dead pulses go to the channel whose trigger is high
  assign chanHalt = chanTrig & {`TX_NUM_CHAN{trigHalt}};
  assign chanDead = chanTrig & {`TX_NUM_CHAN{trigDead}};

  // Next pointer valid levels, same routing
  assign chanNxtAtomFrmPtrValid = chanTrig & {`TX_NUM_CHAN{nxtAtomFrmPtrValid}};
  assign chanNxtMpduDescValid   = chanTrig & {`TX_NUM_CHAN{nxtMpduDescValid}};

endmodule

//--- src/txErrStatus.sv
// Transmit error status flags

`timescale 1ns/1ps

`include "txSelLogic_params.svh"

module txErrStatus
  import txSelLogicPkg::*;
(
  // Clock and resets
  input  logic     macPITxClk,
  input  logic     macPITxClkHardRst_n,
  input  logic     macPITxClkSoftRst_n,
  // Active channel
  input  chanVec_t chanTrig,
  // Error sources
  input  logic     trigDead,
  input  logic     underRunDetected,
  input  logic     patternError,
  input  logic     dmaHifError,
  input  logic     plyTblValid,
  input  logic     nxtAtomFrmPtrValid,
  input  logic     nxtMpduDescValid,
  // DMA status register flags, one bit per channel
  output chanVec_t txLenMismatch,
  output chanVec_t txUPatternErr,
  output chanVec_t txBusErr,
  output chanVec_t txPtAddressErr,
  output chanVec_t txNextPointerErr
);

  // Channel that receives the dead pulse
  chanVec_t deadVec;
  // Per-flag set vectors
  chanVec_t lenSet;
  chanVec_t patSet;
  chanVec_t busSet;
  chanVec_t ptSet;
  chanVec_t nxtSet;
  // Next pointer fault with no higher priority error
  logic     nxtPtrBad;

  // --------------------------------------------------------------------------
  // Set conditions
  // --------------------------------------------------------------------------

  // Dead pulse qualified by the active channel
  assign deadVec = chanTrig & {`TX_NUM_CHAN{trigDead}};

  // Underrun from the MAC controller, no dead pulse needed
  assign lenSet = chanTrig & {`TX_NUM_CHAN{underRunDetected}};

  // Unique pattern mismatch found by the list processor
  assign patSet = deadVec & {`TX_NUM_CHAN{patternError}};

  // Error response on the host bus
  assign busSet = deadVec & {`TX_NUM_CHAN{dmaHifError}};

  // No valid policy table address in the header descriptor
  assign ptSet  = deadVec & {`TX_NUM_CHAN{~plyTblValid}};

  // Invalid next atomic frame or next MPDU pointer
  // Masked by pattern, bus and policy table errors
  assign nxtPtrBad = !patternError && !dmaHifError && plyTblValid &&
                     (!nxtAtomFrmPtrValid || !nxtMpduDescValid);

  assign nxtSet = deadVec & {`TX_NUM_CHAN{nxtPtrBad}};

  // --------------------------------------------------------------------------
  // Sticky flags
  // --------------------------------------------------------------------------

  // Each flag sets on its condition and holds
  // Cleared by hard or soft reset only
  always_ff @(posedge macPITxClk or negedge macPITxClkHardRst_n)
  begin
    if (!macPITxClkHardRst_n)
    begin
      txLenMismatch    <= '0;
      txUPatternErr    <= '0;
      txBusErr         <= '0;
      txPtAddressErr   <= '0;
      txNextPointerErr <= '0;
    end
    else if (!macPITxClkSoftRst_n)
    begin
      txLenMismatch    <= '0;
      txUPatternErr    <= '0;
      txBusErr         <= '0;
      txPtAddressErr   <= '0;
      txNextPointerErr <= '0;
    end
    else
    begin
      // OR in new events, bits already set stay set
      txLenMismatch    <= txLenMismatch    | lenSet;
      txUPatternErr    <= txUPatternErr    | patSet;
      txBusErr         <= txBusErr         | busSet;
      txPtAddressErr   <= txPtAddressErr   | ptSet;
      txNextPointerErr <= txNextPointerErr | nxtSet;
    end
  end

endmodule

//--- src/txPrimCtrlSelLogic.sv
// Transmit primary controller select

`timescale 1ns/1ps

module txPrimCtrlSelLogic
  import txSelLogicPkg::*;
(
  // Clock and resets
  input  logic          macPITxClk,
  input  logic          macPITxClkHardRst_n,
  input  logic          macPITxClkSoftRst_n,
  // Primary controllers
  input  chanVec_t      chanTrig,
  input  statusPtrArr_t chanStatusPtr,
  // List processor and MAC controller
  input  logic          trigHalt,
  input  logic          trigDead,
  input  logic          underRunDetected,
  input  logic          patternError,
  input  logic          dmaHifError,
  input  logic          plyTblValid,
  input  logic          nxtAtomFrmPtrValid,
  input  logic          nxtMpduDescValid,
  // Towards the list processor
  output logic          trigTxListProc,
  output statusPtr_t    statusPointer,
  // Routed strobes towards the primary controllers
  output chanVec_t      chanHalt,
  output chanVec_t      chanDead,
  output chanVec_t      chanNxtAtomFrmPtrValid,
  output chanVec_t      chanNxtMpduDescValid,
  // DMA status register flags
  output chanVec_t      txLenMismatch,
  output chanVec_t      txUPatternErr,
  output chanVec_t      txBusErr,
  output chanVec_t      txPtAddressErr,
  output chanVec_t      txNextPointerErr
);

  // --------------------------------------------------------------------------
  // Channel router
  // --------------------------------------------------------------------------

  // Select capture, pointer mux and strobe demux
  txChanRouter u_chanRouter (
    .macPITxClk             (macPITxClk),
    .macPITxClkHardRst_n    (macPITxClkHardRst_n),
    .macPITxClkSoftRst_n    (macPITxClkSoftRst_n),
    .chanTrig               (chanTrig),
    .chanStatusPtr          (chanStatusPtr),
    .trigHalt               (trigHalt),
    .trigDead               (trigDead),
    .nxtAtomFrmPtrValid     (nxtAtomFrmPtrValid),
    .nxtMpduDescValid       (nxtMpduDescValid),
    .trigTxListProc         (trigTxListProc),
    .statusPointer          (statusPointer),
    .chanHalt               (chanHalt),
    .chanDead               (chanDead),
    .chanNxtAtomFrmPtrValid (chanNxtAtomFrmPtrValid),
    .chanNxtMpduDescValid   (chanNxtMpduDescValid)
  );

  // --------------------------------------------------------------------------
  // Error status capture
  // --------------------------------------------------------------------------

  // Sticky per-channel flags, independent of the router outputs
  txErrStatus u_errStatus (
    .macPITxClk          (macPITxClk),
    .macPITxClkHardRst_n (macPITxClkHardRst_n),
    .macPITxClkSoftRst_n (macPITxClkSoftRst_n),
    .chanTrig            (chanTrig),
    .trigDead            (trigDead),
    .underRunDetected    (underRunDetected),
    .patternError        (patternError),
    .dmaHifError         (dmaHifError),
    .plyTblValid         (plyTblValid),
    .nxtAtomFrmPtrValid  (nxtAtomFrmPtrValid),
    .nxtMpduDescValid    (nxtMpduDescValid),
    .txLenMismatch       (txLenMismatch),
    .txUPatternErr       (txUPatternErr),
    .txBusErr            (txBusErr),
    .txPtAddressErr      (txPtAddressErr),
    .txNextPointerErr    (txNextPointerErr)
  );

endmodule

//--- verification/txPrimCtrlSelLogic_assert.sv
// Select logic assertions

`timescale 1ns/1ps

`include "txSelLogic_params.svh"

module txPrimCtrlSelLogic_assert
  import txSelLogicPkg::*;
(
  input logic       macPITxClk,
  input logic       macPITxClkHardRst_n,
  input logic       macPITxClkSoftRst_n,
  input chanVec_t   chanTrig,
  input statusPtr_t statusPointer,
  input chanVec_t   chanHalt,
  input chanVec_t   chanDead,
  input chanVec_t   chanNxtAtomFrmPtrValid,
  input chanVec_t   chanNxtMpduDescValid,
  input chanVec_t   txLenMismatch,
  input chanVec_t   txUPatternErr,
  input chanVec_t   txBusErr,
  input chanVec_t   txPtAddressErr,
  input chanVec_t   txNextPointerErr
);

  // All sticky flags side by side
  logic [5*`TX_NUM_CHAN-1:0] allFlags;

  assign allFlags = {txLenMismatch, txUPatternErr, txBusErr,
                     txPtAddressErr, txNextPointerErr};

  // Routed strobes only reach a triggered channel
  strobeSubset: assert property (@(posedge macPITxClk) disable iff (!macPITxClkHardRst_n)
    ((chanHalt | chanDead | chanNxtAtomFrmPtrValid | chanNxtMpduDescValid) & ~chanTrig) == '0)
    else $error("routed strobe seen on a channel whose trigger is low");

  // A set flag only drops after a soft reset on the previous edge
  flagSticky: assert property (@(posedge macPITxClk) disable iff (!macPITxClkHardRst_n)
    $past(macPITxClkSoftRst_n) |-> (($past(allFlags) & ~allFlags) == '0))
    else $error("error flag cleared without a reset");

  // Reset empties the select, so the mux gives zero
  ptrZeroAfterRst: assert property (@(posedge macPITxClk)
    (!macPITxClkHardRst_n || !macPITxClkSoftRst_n) |=> (statusPointer == '0))
    else $error("status pointer not zero one cycle after reset");

endmodule

// Attach to every instance of the top level
bind txPrimCtrlSelLogic txPrimCtrlSelLogic_assert u_assert (.*);

//--- verification/txPrimCtrlSelLogicTb.sv
// Transmit select logic testbench

`timescale 1ns/1ps

`include "txSelLogic_params.svh"

module txPrimCtrlSelLogicTb
  import txSelLogicPkg::*;
();

  // One table row
  // Flag vectors are cumulative over the run
  typedef struct packed {
    chanVec_t   trig;
    logic [8:0] ctl;
    logic [2:0] expIdx;
    chanVec_t   expLen;
    chanVec_t   expPat;
    chanVec_t   expBus;
    chanVec_t   expPt;
    chanVec_t   expNxt;
  } testEntry_t;

  // Control bits of a row
  // All zero is the idle state
  localparam logic [8:0] none    = 9'h000;
  localparam logic [8:0] halt    = 9'h001;
  localparam logic [8:0] dead    = 9'h002;
  localparam logic [8:0] under   = 9'h004;
  localparam logic [8:0] pat     = 9'h008;
  localparam logic [8:0] bus     = 9'h010;
  localparam logic [8:0] plyBad  = 9'h020;
  localparam logic [8:0] atomBad = 9'h040;
  localparam logic [8:0] mpduBad = 9'h080;
  localparam logic [8:0] softRst = 9'h100;

  // One-hot channel vectors
  localparam chanVec_t bcn = chanVec_t'(1 << `TX_CHAN_BCN);
  localparam chanVec_t ac0 = chanVec_t'(1 << `TX_CHAN_AC0);
  localparam chanVec_t ac1 = chanVec_t'(1 << `TX_CHAN_AC1);
  localparam chanVec_t ac2 = chanVec_t'(1 << `TX_CHAN_AC2);
  localparam chanVec_t ac3 = chanVec_t'(1 << `TX_CHAN_AC3);

  // Expected status pointer index per channel
  // noIdx stands for an empty select
  localparam logic [2:0] bcnIdx = 3'(`TX_CHAN_BCN);
  localparam logic [2:0] ac0Idx = 3'(`TX_CHAN_AC0);
  localparam logic [2:0] ac1Idx = 3'(`TX_CHAN_AC1);
  localparam logic [2:0] ac2Idx = 3'(`TX_CHAN_AC2);
  localparam logic [2:0] ac3Idx = 3'(`TX_CHAN_AC3);
  localparam logic [2:0] noIdx  = 3'd7;

  // DUT ports
  logic          macPITxClk;
  logic          macPITxClkHardRst_n;
  logic          macPITxClkSoftRst_n;
  chanVec_t      chanTrig;
  statusPtrArr_t chanStatusPtr;
  logic          trigHalt;
  logic          trigDead;
  logic          underRunDetected;
  logic          patternError;
  logic          dmaHifError;
  logic          plyTblValid;
  logic          nxtAtomFrmPtrValid;
  logic          nxtMpduDescValid;
  logic          trigTxListProc;
  statusPtr_t    statusPointer;
  chanVec_t      chanHalt;
  chanVec_t      chanDead;
  chanVec_t      chanNxtAtomFrmPtrValid;
  chanVec_t      chanNxtMpduDescValid;
  chanVec_t      txLenMismatch;
  chanVec_t      txUPatternErr;
  chanVec_t      txBusErr;
  chanVec_t      txPtAddressErr;
  chanVec_t      txNextPointerErr;

  // Test table and bookkeeping
  testEntry_t  testQ[$];
  string       nameQ[$];
  int          errCount = 0;
  int          passCount = 0;
  int          failCount = 0;
  int unsigned lcgState = 25993;

  txPrimCtrlSelLogic u_dut (.*);

  // 10 ns clock
  initial macPITxClk = 1'b0;
  always #5 macPITxClk = ~macPITxClk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  task automatic addTest(input string name, input chanVec_t trig, input logic [8:0] ctl,
                         input logic [2:0] idx, input chanVec_t lenF, input chanVec_t patF,
                         input chanVec_t busF, input chanVec_t ptF, input chanVec_t nxtF);
    testQ.push_back({trig, ctl, idx, lenF, patF, busF, ptF, nxtF});
    nameQ.push_back(name);
  endtask

  task automatic driveInputs(input chanVec_t trig, input logic [8:0] ctl);
    chanTrig            <= trig;
    trigHalt            <= |(ctl & halt);
    trigDead            <= |(ctl & dead);
    underRunDetected    <= |(ctl & under);
    patternError        <= |(ctl & pat);
    dmaHifError         <= |(ctl & bus);
    plyTblValid         <= ~|(ctl & plyBad);
    nxtAtomFrmPtrValid  <= ~|(ctl & atomBad);
    nxtMpduDescValid    <= ~|(ctl & mpduBad);
    macPITxClkSoftRst_n <= ~|(ctl & softRst);
  endtask

  task automatic checkValue(input string testName, input string what,
                            input logic [31:0] expVal, input logic [31:0] actVal);
    if (expVal !== actVal)
    begin
      $display("FAIL %s %s expected %h actual %h", testName, what, expVal, actVal);
      errCount++;
    end
  endtask

  // --------------------------------------------------------------------------
  // One table row
  // --------------------------------------------------------------------------

  task automatic runTest(input int idx);
    testEntry_t e;
    string      name;
    int         errBefore;
    statusPtr_t expPtr;
    e = testQ[idx];
    name = nameQ[idx];
    errBefore = errCount;
    // Row inputs for one cycle
    @(posedge macPITxClk);
    driveInputs(e.trig, e.ctl);
    // Zero-latency outputs read mid-cycle
    @(negedge macPITxClk);
    checkValue(name, "trigTxListProc", 32'(|e.trig), 32'(trigTxListProc));
    checkValue(name, "chanHalt", 32'(|(e.ctl & halt) ? e.trig : 5'h00), 32'(chanHalt));
    checkValue(name, "chanDead", 32'(|(e.ctl & dead) ? e.trig : 5'h00), 32'(chanDead));
    checkValue(name, "chanNxtAtom", 32'(|(e.ctl & atomBad) ? 5'h00 : e.trig),
               32'(chanNxtAtomFrmPtrValid));
    checkValue(name, "chanNxtMpdu", 32'(|(e.ctl & mpduBad) ? 5'h00 : e.trig),
               32'(chanNxtMpduDescValid));
    // Pulses end here while the trigger level is held
    @(posedge macPITxClk);
    driveInputs(e.trig, none);
    // Select and flags have taken the edge
    @(negedge macPITxClk);
    expPtr = (e.expIdx == noIdx) ? '0 : chanStatusPtr[e.expIdx];
    checkValue(name, "statusPointer", expPtr, statusPointer);
    checkValue(name, "txLenMismatch", 32'(e.expLen), 32'(txLenMismatch));
    checkValue(name, "txUPatternErr", 32'(e.expPat), 32'(txUPatternErr));
    checkValue(name, "txBusErr", 32'(e.expBus), 32'(txBusErr));
    checkValue(name, "txPtAddressErr", 32'(e.expPt), 32'(txPtAddressErr));
    checkValue(name, "txNextPointerErr", 32'(e.expNxt), 32'(txNextPointerErr));
    if (errCount == errBefore)
    begin
      passCount++;
      $display("test %s ok", name);
    end
    else
    begin
      failCount++;
      $display("test %s had errors", name);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial
  begin
    macPITxClkHardRst_n <= 1'b0;
    driveInputs(5'h00, none);
    for (int c = 0; c < `TX_NUM_CHAN; c++)
      chanStatusPtr[c] <= lcgNext();
    // First line of a row gives name, trigger, controls and pointer index
    // Second line gives the expected len, pat, bus, pt and nxt flags
    addTest("strobeNoChan", 5'h00, halt | dead,          noIdx,
            5'h00, 5'h00, 5'h00, 5'h00, 5'h00);
    addTest("bcnRaise",     bcn,   none,                 bcnIdx,
            5'h00, 5'h00, 5'h00, 5'h00, 5'h00);
    addTest("bcnHalt",      bcn,   halt,                 bcnIdx,
            5'h00, 5'h00, 5'h00, 5'h00, 5'h00);
    addTest("bcnPatErr",    bcn,   dead | pat,           bcnIdx,
            5'h00, 5'h10, 5'h00, 5'h00, 5'h00);
    addTest("bcnDrop",      5'h00, none,                 bcnIdx,
            5'h00, 5'h10, 5'h00, 5'h00, 5'h00);
    addTest("ac0Raise",     ac0,   none,                 ac0Idx,
            5'h00, 5'h10, 5'h00, 5'h00, 5'h00);
    addTest("ac0BusErr",    ac0,   dead | bus,           ac0Idx,
            5'h00, 5'h10, 5'h08, 5'h00, 5'h00);
    addTest("ac0Drop",      5'h00, none,                 ac0Idx,
            5'h00, 5'h10, 5'h08, 5'h00, 5'h00);
    addTest("ac1Raise",     ac1,   none,                 ac1Idx,
            5'h00, 5'h10, 5'h08, 5'h00, 5'h00);
    addTest("ac1PlyErr",    ac1,   dead | plyBad,        ac1Idx,
            5'h00, 5'h10, 5'h08, 5'h04, 5'h00);
    addTest("ac1Drop",      5'h00, none,                 ac1Idx,
            5'h00, 5'h10, 5'h08, 5'h04, 5'h00);
    addTest("ac2Raise",     ac2,   none,                 ac2Idx,
            5'h00, 5'h10, 5'h08, 5'h04, 5'h00);
    // Pattern error masks the next pointer error
    addTest("ac2NxtMasked", ac2,   dead | pat | mpduBad, ac2Idx,
            5'h00, 5'h12, 5'h08, 5'h04, 5'h00);
    addTest("ac2NxtErr",    ac2,   dead | atomBad,       ac2Idx,
            5'h00, 5'h12, 5'h08, 5'h04, 5'h02);
    addTest("ac2Drop",      5'h00, none,                 ac2Idx,
            5'h00, 5'h12, 5'h08, 5'h04, 5'h02);
    addTest("ac3Raise",     ac3,   none,                 ac3Idx,
            5'h00, 5'h12, 5'h08, 5'h04, 5'h02);
    addTest("ac3UnderRun",  ac3,   under,                ac3Idx,
            5'h01, 5'h12, 5'h08, 5'h04, 5'h02);
    addTest("ac3Drop",      5'h00, none,                 ac3Idx,
            5'h01, 5'h12, 5'h08, 5'h04, 5'h02);
    addTest("softReset",    5'h00, softRst,              noIdx,
            5'h00, 5'h00, 5'h00, 5'h00, 5'h00);
    // Hard reset for 10 cycles
    repeat (10) @(posedge macPITxClk);
    macPITxClkHardRst_n <= 1'b1;
    for (int i = 0; i < testQ.size(); i++)
      runTest(i);
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (errCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Watchdog allows 20 cycles per row plus the reset time
  initial
  begin
    int limit;
    #1;
    limit = testQ.size() * 20 + 10;
    repeat (limit) @(posedge macPITxClk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- txSelLogic.f
+incdir+include
src/txSelLogicPkg.sv
src/txChanRouter.sv
src/txErrStatus.sv
src/txPrimCtrlSelLogic.sv
verification/txPrimCtrlSelLogic_assert.sv
verification/txPrimCtrlSelLogicTb.sv

//--- build.sh
#!/bin/sh
# Build and run the transmit select logic testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f txSelLogic.f \
  --top-module txPrimCtrlSelLogicTb -o simTb

# A simulator that stops on its own, for example on an assertion, also fails the run
./obj_dir/simTb > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
